// ==== src/lsu_settings.svh ====
/*
 * L1.5 message codes for the load/store path.
 * Only the codes this path uses; no zero-size or atomic requests.
 */
`ifndef LSU_SETTINGS_SVH
`define LSU_SETTINGS_SVH

// request types
`define L15_LOAD_RQ   4'b0000
`define L15_STORE_RQ  4'b0001

// return types
`define L15_LOAD_RET  4'b0000
`define L15_ST_ACK    4'b0100
`define L15_INT_RET   4'b0111    // interrupt return, dropped by the LSU

// message sizes
`define MSG_SIZE_1B   3'b001
`define MSG_SIZE_2B   3'b010
`define MSG_SIZE_4B   3'b011

`endif

// ==== src/lsu_pkg.sv ====
/*
 * Opcode and request FSM types for the LSU.
 * Opcode bit 3 = store, bits 2:1 = width (11 word, 01 half, 10 byte), bit 0 = signed.
 */
package lsu_pkg;

    typedef enum logic [3:0] {
        op_none = 4'b0000,
        op_sw   = 4'b1111,
        op_sh   = 4'b1011,
        op_sb   = 4'b1101,
        op_lw   = 4'b0111,
        op_lh   = 4'b0011,
        op_lhu  = 4'b0010,
        op_lb   = 4'b0101,
        op_lbu  = 4'b0100
    } mem_op_e;

    typedef enum logic [1:0] {
        st_ready,
        st_send,
        st_wait,
        st_done
    } req_state_e;

    function automatic logic is_store(mem_op_e op);
        return op[3];
    endfunction

    function automatic logic is_word(mem_op_e op);
        return op[2:1] == 2'b11;
    endfunction

    function automatic logic is_half(mem_op_e op);
        return op[2:1] == 2'b01;
    endfunction

    function automatic logic is_byte(mem_op_e op);
        return op[2:1] == 2'b10;
    endfunction

    function automatic logic is_signed(mem_op_e op);
        return op[0];
    endfunction

endpackage

// ==== src/lsu_addr_stage.sv ====
/*
 * Two-stage address decode. Takes a new op only while accept is high and
 * both stages are empty, so a held core op is captured once.
 * byte_en is only set for aligned stores; store data is replicated per lane.
 */
`timescale 1ns/1ns

module lsu_addr_stage
    import lsu_pkg::*;
(
    input  logic        clk,
    input  logic        nrst,
    input  mem_op_e     mem_op,
    input  logic [31:0] op_a,
    input  logic [31:0] op_b,
    input  logic [31:0] s_imm,
    input  logic        accept,

    output logic [31:0] addr,
    output logic [31:0] wdata,
    output logic [3:0]  byte_en,
    output logic        rd,
    output logic        wr,
    output logic        valid_op,
    output logic        ld_misaligned,
    output logic        st_misaligned,
    output mem_op_e     op
);

    mem_op_e     op1;        // stage one opcode
    logic [31:0] a1;
    logic [31:0] b1;
    logic [31:0] imm1;
    logic        take;
    logic [31:0] ea;         // effective address
    logic        mis;
    logic [3:0]  be;
    logic [31:0] wd;

    // one op in flight at a time
    assign take = accept && (op1 == op_none) && !valid_op;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            op1 <= op_none;
        end else begin
            op1 <= take ? mem_op : op_none;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            a1   <= op_a;
            b1   <= op_b;
            imm1 <= s_imm;
        end
    end

    assign ea  = is_store(op1) ? a1 + imm1 : a1 + b1;
    assign mis = (is_half(op1) && ea[0]) || (is_word(op1) && (ea[1:0] != 2'b00));

    // write lanes, bit i is byte i of the word
    always_comb begin
        be = 4'b0000;
        if (is_store(op1) && !mis) begin
            if (is_word(op1)) begin
                be = 4'b1111;
            end else if (is_half(op1)) begin
                be = ea[1] ? 4'b1100 : 4'b0011;
            end else if (is_byte(op1)) begin
                be = 4'b0001 << ea[1:0];
            end
        end
    end

    // replicate narrow store data so every lane carries it
    always_comb begin
        if (is_half(op1)) begin
            wd = {2{b1[15:0]}};
        end else if (is_byte(op1)) begin
            wd = {4{b1[7:0]}};
        end else begin
            wd = b1;
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            rd            <= 1'b0;
            wr            <= 1'b0;
            valid_op      <= 1'b0;
            ld_misaligned <= 1'b0;
            st_misaligned <= 1'b0;
            op            <= op_none;
        end else begin
            rd            <= (op1 != op_none) && !is_store(op1) && !mis;
            wr            <= is_store(op1) && !mis;
            valid_op      <= op1 != op_none;
            ld_misaligned <= mis && !is_store(op1);
            st_misaligned <= mis && is_store(op1);
            op            <= op1;
        end
    end

    always_ff @(posedge clk) begin
        addr    <= ea;
        wdata   <= wd;
        byte_en <= be;
    end

    // a flagged op must never also strobe a memory access
    a_mis_excl: assert property (@(posedge clk) disable iff (!nrst)
        !(ld_misaligned && st_misaligned) && !((ld_misaligned || st_misaligned) && (rd || wr)));

endmodule

// ==== src/lsu_l15_req.sv ====
/*
 * Issues one L1.5 request per op and waits for its matching return.
 * Non-matching returns (e.g. interrupts) are acked and dropped.
 * Loads are sent word aligned with size 4B; store data goes out big-endian.
 */
`timescale 1ns/1ns
`include "lsu_settings.svh"

module lsu_l15_req
    import lsu_pkg::*;
(
    input  logic          clk,
    input  logic          nrst,

    // from address stage
    input  logic [31:0]   addr,
    input  logic [31:0]   wdata,
    input  logic [3:0]    byte_en,
    input  logic          rd,
    input  logic          wr,
    input  logic          valid_op,
    input  logic          ld_misaligned,
    input  logic          st_misaligned,
    input  mem_op_e       op,

    // L1.5 handshake
    input  logic          l15_ack,
    input  logic          l15_header_ack,
    input  logic          l15_resp_val,
    input  logic [3:0]    l15_returntype,
    input  logic [63:0]   l15_data_0,
    input  logic [63:0]   l15_data_1,

    output logic [3:0]    l15_rqtype,
    output logic [2:0]    l15_size,
    output logic [31:0]   l15_address,
    output logic [31:0]   l15_data,
    output logic          l15_val,
    output logic          l15_req_ack,

    // to address stage and load align
    output logic          accept,
    output logic          finish,
    output logic [127:0]  resp_data,
    output logic [31:0]   fin_addr,
    output mem_op_e       fin_op,
    output logic          fin_ld_mis,
    output logic          fin_st_mis
);

    req_state_e  state;
    logic        take;
    logic        mis;
    logic        fire;
    logic        resp_ok;
    logic        fin_q;      // done cycle, keep the address stage closed
    logic [3:0]  exp_ret;
    logic [2:0]  size_sel;

    assign take    = (state == st_ready) && valid_op;
    assign mis     = ld_misaligned || st_misaligned;
    assign fire    = l15_val && l15_ack && l15_header_ack;
    assign exp_ret = is_store(fin_op) ? `L15_ST_ACK : `L15_LOAD_RET;

    // every response in st_wait is acked, only a matching one ends the op
    assign l15_req_ack = (state == st_wait) && l15_resp_val;
    assign resp_ok     = l15_req_ack && (l15_returntype == exp_ret);

    assign accept = (state == st_ready) && !fin_q;
    assign finish = state == st_done;

    always_comb begin
        if (rd) begin
            size_sel = `MSG_SIZE_4B;        // loads fetch the whole word
        end else begin
            case (byte_en)
                4'b1111:                            size_sel = `MSG_SIZE_4B;
                4'b0011, 4'b1100:                   size_sel = `MSG_SIZE_2B;
                4'b0001, 4'b0010, 4'b0100, 4'b1000: size_sel = `MSG_SIZE_1B;
                default:                            size_sel = `MSG_SIZE_4B;
            endcase
        end
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state      <= st_ready;
            l15_val    <= 1'b0;
            fin_op     <= op_none;
            fin_ld_mis <= 1'b0;
            fin_st_mis <= 1'b0;
            fin_q      <= 1'b0;
        end else begin
            fin_q <= finish;
            case (state)
                st_ready: begin
                    if (take) begin
                        fin_op     <= op;
                        fin_ld_mis <= ld_misaligned;
                        fin_st_mis <= st_misaligned;
                        if (mis) begin
                            state <= st_done;   // no request for a bad address
                        end else begin
                            state   <= st_send;
                            l15_val <= 1'b1;
                        end
                    end
                end
                st_send: begin
                    if (fire) begin
                        l15_val <= 1'b0;
                        state   <= st_wait;
                    end
                end
                st_wait: begin
                    if (resp_ok) begin
                        state <= st_done;
                    end
                end
                st_done: begin
                    state <= st_ready;
                end
                default: begin
                    state <= st_ready;
                end
            endcase
        end
    end

    // request fields held from take until fire
    always_ff @(posedge clk) begin
        if (take) begin
            fin_addr    <= addr;
            l15_rqtype  <= wr ? `L15_STORE_RQ : `L15_LOAD_RQ;
            l15_size    <= size_sel;
            l15_address <= rd ? {addr[31:2], 2'b00} : addr;
            l15_data    <= {wdata[7:0], wdata[15:8], wdata[23:16], wdata[31:24]};
        end
        if (resp_ok) begin
            resp_data <= {l15_data_0, l15_data_1};
        end
    end

    a_req_hold: assert property (@(posedge clk) disable iff (!nrst)
        (l15_val && !(l15_ack && l15_header_ack)) |=>
            (l15_val && $stable(l15_rqtype) && $stable(l15_size)
             && $stable(l15_address) && $stable(l15_data)));

    // returns are acked only with no request pending and end or keep the wait
    a_req_ack_wait: assert property (@(posedge clk) disable iff (!nrst)
        l15_req_ack |-> !l15_val ##1 (state == st_wait || state == st_done));

endmodule

// ==== src/lsu_load_align.sv ====
/*
 * Picks the addressed word from a 16-byte big-endian return and extends it.
 * load_data only changes on an aligned load; flags pulse together with done.
 */
`timescale 1ns/1ns

module lsu_load_align
    import lsu_pkg::*;
(
    input  logic          clk,
    input  logic          nrst,
    input  logic          finish,
    input  logic [127:0]  resp_data,
    input  logic [31:0]   fin_addr,
    input  mem_op_e       fin_op,
    input  logic          fin_ld_mis,
    input  logic          fin_st_mis,

    output logic [31:0]   load_data,
    output logic          done,
    output logic          ld_misaligned,
    output logic          st_misaligned
);

    logic [31:0] lane_be;    // word as returned, big-endian
    logic [31:0] lane;
    logic [7:0]  sel_b;
    logic [15:0] sel_h;
    logic [31:0] ext;
    logic        ld_upd;

    // lane 0 is the upper half of data_0
    always_comb begin
        case (fin_addr[3:2])
            2'd0:    lane_be = resp_data[127:96];
            2'd1:    lane_be = resp_data[95:64];
            2'd2:    lane_be = resp_data[63:32];
            default: lane_be = resp_data[31:0];
        endcase
    end

    assign lane  = {lane_be[7:0], lane_be[15:8], lane_be[23:16], lane_be[31:24]};
    assign sel_b = lane[{fin_addr[1:0], 3'b000} +: 8];
    assign sel_h = lane[{fin_addr[1], 4'b0000} +: 16];

    always_comb begin
        if (is_word(fin_op)) begin
            ext = lane;
        end else if (is_half(fin_op)) begin
            ext = is_signed(fin_op) ? {{16{sel_h[15]}}, sel_h} : {16'h0000, sel_h};
        end else begin
            ext = is_signed(fin_op) ? {{24{sel_b[7]}}, sel_b} : {24'h000000, sel_b};
        end
    end

    assign ld_upd = finish && !is_store(fin_op) && !fin_ld_mis;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            done          <= 1'b0;
            ld_misaligned <= 1'b0;
            st_misaligned <= 1'b0;
        end else begin
            done          <= finish;
            ld_misaligned <= finish && fin_ld_mis;
            st_misaligned <= finish && fin_st_mis;
        end
    end

    always_ff @(posedge clk) begin
        if (ld_upd) begin
            load_data <= ext;   // held until the next load
        end
    end

endmodule

// ==== src/lsu_top.sv ====
/*
 * Load/store path top: address stage, L1.5 request FSM, load align.
 * One op at a time; the core holds its op until done.
 */
`timescale 1ns/1ns

module lsu_top
    import lsu_pkg::*;
(
    input  logic         clk,
    input  logic         nrst,

    // core side
    input  mem_op_e      mem_op,
    input  logic [31:0]  op_a,
    input  logic [31:0]  op_b,
    input  logic [31:0]  s_imm,

    // L1.5 side
    input  logic         l15_ack,
    input  logic         l15_header_ack,
    input  logic         l15_resp_val,
    input  logic [3:0]   l15_returntype,
    input  logic [63:0]  l15_data_0,
    input  logic [63:0]  l15_data_1,

    output logic [3:0]   l15_rqtype,
    output logic [2:0]   l15_size,
    output logic [31:0]  l15_address,
    output logic [31:0]  l15_data,
    output logic         l15_val,
    output logic         l15_req_ack,

    output logic [31:0]  load_data,
    output logic         done,
    output logic         ld_misaligned,
    output logic         st_misaligned
);

    // address stage -> request
    logic [31:0]  a_addr;
    logic [31:0]  a_wdata;
    logic [3:0]   a_byte_en;
    logic         a_rd;
    logic         a_wr;
    logic         a_valid;
    logic         a_ld_mis;
    logic         a_st_mis;
    mem_op_e      a_op;
    logic         accept;

    // request -> load align
    logic         finish;
    logic [127:0] resp_data;
    logic [31:0]  fin_addr;
    mem_op_e      fin_op;
    logic         fin_ld_mis;
    logic         fin_st_mis;

    lsu_addr_stage u_addr (
        .clk           (clk),
        .nrst          (nrst),
        .mem_op        (mem_op),
        .op_a          (op_a),
        .op_b          (op_b),
        .s_imm         (s_imm),
        .accept        (accept),
        .addr          (a_addr),
        .wdata         (a_wdata),
        .byte_en       (a_byte_en),
        .rd            (a_rd),
        .wr            (a_wr),
        .valid_op      (a_valid),
        .ld_misaligned (a_ld_mis),
        .st_misaligned (a_st_mis),
        .op            (a_op)
    );

    lsu_l15_req u_req (
        .clk            (clk),
        .nrst           (nrst),
        .addr           (a_addr),
        .wdata          (a_wdata),
        .byte_en        (a_byte_en),
        .rd             (a_rd),
        .wr             (a_wr),
        .valid_op       (a_valid),
        .ld_misaligned  (a_ld_mis),
        .st_misaligned  (a_st_mis),
        .op             (a_op),
        .l15_ack        (l15_ack),
        .l15_header_ack (l15_header_ack),
        .l15_resp_val   (l15_resp_val),
        .l15_returntype (l15_returntype),
        .l15_data_0     (l15_data_0),
        .l15_data_1     (l15_data_1),
        .l15_rqtype     (l15_rqtype),
        .l15_size       (l15_size),
        .l15_address    (l15_address),
        .l15_data       (l15_data),
        .l15_val        (l15_val),
        .l15_req_ack    (l15_req_ack),
        .accept         (accept),
        .finish         (finish),
        .resp_data      (resp_data),
        .fin_addr       (fin_addr),
        .fin_op         (fin_op),
        .fin_ld_mis     (fin_ld_mis),
        .fin_st_mis     (fin_st_mis)
    );

    lsu_load_align u_align (
        .clk           (clk),
        .nrst          (nrst),
        .finish        (finish),
        .resp_data     (resp_data),
        .fin_addr      (fin_addr),
        .fin_op        (fin_op),
        .fin_ld_mis    (fin_ld_mis),
        .fin_st_mis    (fin_st_mis),
        .load_data     (load_data),
        .done          (done),
        .ld_misaligned (ld_misaligned),
        .st_misaligned (st_misaligned)
    );

endmodule

// ==== test/tb_l15_model.sv ====
/*
 * Behavioral L1.5: 256-byte memory on address bits 7:0, one request at a time.
 * Ack is held back 0 to 4 cycles; int_en sends an interrupt return before the real one.
 * Outputs change 2 ns after the rising edge.
 */
`timescale 1ns/1ns
`include "lsu_settings.svh"

module tb_l15_model (
    input  logic        clk,
    input  logic        nrst,
    input  logic        int_en,
    input  logic [3:0]  l15_rqtype,
    input  logic [2:0]  l15_size,
    input  logic [31:0] l15_address,
    input  logic [31:0] l15_data,
    input  logic        l15_val,
    input  logic        l15_req_ack,
    output logic        l15_ack,
    output logic        l15_header_ack,
    output logic        l15_resp_val,
    output logic [3:0]  l15_returntype,
    output logic [63:0] l15_data_0,
    output logic [63:0] l15_data_1
);

    logic [7:0]  mem [0:255];
    logic [3:0]  rq_type;
    logic [2:0]  rq_size;
    logic [31:0] rq_addr;
    logic [31:0] rq_data;
    logic [63:0] d0;
    logic [63:0] d1;
    int unsigned wait_cycles;

    // hold the return until the LSU acks it
    task automatic return_msg(input logic [3:0] rtype, input logic [63:0] hi,
                              input logic [63:0] lo);
        l15_resp_val   = 1'b1;
        l15_returntype = rtype;
        l15_data_0     = hi;
        l15_data_1     = lo;
        do begin
            @(negedge clk);
        end while (l15_req_ack !== 1'b1);
        @(posedge clk);
        #2;
        l15_resp_val = 1'b0;
    endtask

    task automatic write_bytes();
        int         n;
        logic [7:0] a;
        n = (rq_size == `MSG_SIZE_4B) ? 4 : (rq_size == `MSG_SIZE_2B) ? 2 : 1;
        for (int j = 0; j < n; j++) begin
            a = rq_addr[7:0] + 8'(j);
            mem[a] = rq_data[31 - 8 * a[1:0] -: 8];    // big-endian lanes
        end
    endtask

    // 16-byte line, lowest address in the top byte of data_0
    task automatic read_line();
        logic [7:0] line;
        line = {rq_addr[7:4], 4'h0};
        for (int k = 0; k < 8; k++) begin
            d0 = {d0[55:0], mem[line + 8'(k)]};
            d1 = {d1[55:0], mem[line + 8'(k + 8)]};
        end
    endtask

    initial begin
        l15_ack        = 1'b0;
        l15_header_ack = 1'b0;
        l15_resp_val   = 1'b0;
        l15_returntype = 4'h0;
        l15_data_0     = 64'h0;
        l15_data_1     = 64'h0;
        for (int i = 0; i < 256; i++) begin
            mem[i] = 8'(i * 29) ^ 8'h5a;
        end
        forever begin
            @(posedge clk);
            #2;
            if (nrst && l15_val) begin
                wait_cycles = $urandom_range(4, 0);
                for (int c = 0; c < wait_cycles; c++) begin
                    // back-pressure, never both acks at once
                    l15_ack        = 1'($urandom_range(1, 0));
                    l15_header_ack = !l15_ack && 1'($urandom_range(1, 0));
                    @(posedge clk);
                    #2;
                end
                rq_type        = l15_rqtype;
                rq_size        = l15_size;
                rq_addr        = l15_address;
                rq_data        = l15_data;
                l15_ack        = 1'b1;
                l15_header_ack = 1'b1;
                @(posedge clk);                        // request fires here
                #2;
                l15_ack        = 1'b0;
                l15_header_ack = 1'b0;
                if (rq_type == `L15_STORE_RQ) begin
                    write_bytes();
                end
                @(posedge clk);
                #2;
                if (int_en) begin
                    return_msg(`L15_INT_RET, {$urandom, $urandom}, {$urandom, $urandom});
                    @(posedge clk);
                    #2;
                end
                if (rq_type == `L15_STORE_RQ) begin
                    return_msg(`L15_ST_ACK, 64'h0, 64'h0);
                end else begin
                    read_line();
                    return_msg(`L15_LOAD_RET, d0, d1);
                end
            end
        end
    end

endmodule

// ==== test/tb_lsu.sv ====
/*
 * Testbench for lsu_top with a behavioral L1.5 behind it.
 * Addresses stay below 256, the size of the model memory.
 * Data and ack delays come from $urandom, seed 9.
 */
`timescale 1ns/1ns
`include "lsu_settings.svh"

module tb_lsu
    import lsu_pkg::*;
();

    localparam int CLK_PERIOD = 20;
    localparam int OP_CYCLES  = 200;
    localparam int N_WORDS    = 4;
    localparam int N_RAND     = 24;
    localparam int N_MIS      = 9;
    localparam int N_INT      = 6;
    localparam int N_OPS      = N_WORDS * 20 + N_RAND + N_MIS + N_INT;

    logic        clk = 1'b0;
    logic        nrst;
    mem_op_e     mem_op;
    logic [31:0] op_a;
    logic [31:0] op_b;
    logic [31:0] s_imm;
    logic        int_en;
    logic        l15_ack;
    logic        l15_header_ack;
    logic        l15_resp_val;
    logic [3:0]  l15_returntype;
    logic [63:0] l15_data_0;
    logic [63:0] l15_data_1;
    logic [3:0]  l15_rqtype;
    logic [2:0]  l15_size;
    logic [31:0] l15_address;
    logic [31:0] l15_data;
    logic        l15_val;
    logic        l15_req_ack;
    logic [31:0] load_data;
    logic        done;
    logic        ld_misaligned;
    logic        st_misaligned;

    logic [7:0]  shadow [0:255];    // expected memory contents
    int          fire_cnt = 0;
    int          ack_cnt = 0;
    int          done_cnt = 0;
    logic        held = 1'b0;
    logic [3:0]  hold_type;
    logic [2:0]  hold_size;
    logic [31:0] hold_addr;
    logic [31:0] hold_data;
    logic [3:0]  last_type;         // last fired request
    logic [2:0]  last_size;
    logic [31:0] last_addr;
    logic [31:0] last_data;

    always #(CLK_PERIOD / 2) clk = ~clk;

    lsu_top uut (
        .clk(clk), .nrst(nrst), .mem_op(mem_op), .op_a(op_a), .op_b(op_b), .s_imm(s_imm),
        .l15_ack(l15_ack), .l15_header_ack(l15_header_ack), .l15_resp_val(l15_resp_val),
        .l15_returntype(l15_returntype), .l15_data_0(l15_data_0), .l15_data_1(l15_data_1),
        .l15_rqtype(l15_rqtype), .l15_size(l15_size), .l15_address(l15_address),
        .l15_data(l15_data), .l15_val(l15_val), .l15_req_ack(l15_req_ack),
        .load_data(load_data), .done(done), .ld_misaligned(ld_misaligned),
        .st_misaligned(st_misaligned)
    );

    tb_l15_model l15 (
        .clk(clk), .nrst(nrst), .int_en(int_en), .l15_rqtype(l15_rqtype),
        .l15_size(l15_size), .l15_address(l15_address), .l15_data(l15_data),
        .l15_val(l15_val), .l15_req_ack(l15_req_ack), .l15_ack(l15_ack),
        .l15_header_ack(l15_header_ack), .l15_resp_val(l15_resp_val),
        .l15_returntype(l15_returntype), .l15_data_0(l15_data_0), .l15_data_1(l15_data_1)
    );

    task automatic stop_run(input string msg);
        $display("Error at %0t ns: %s", $time, msg);
        $display("TEST FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check_val(input logic [31:0] got, input logic [31:0] exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s got 0x%h expected 0x%h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "first mismatch");
        end
    endtask

    function automatic int op_bytes(input mem_op_e op);
        case (op)
            op_sw, op_lw:         return 4;
            op_sh, op_lh, op_lhu: return 2;
            default:              return 1;
        endcase
    endfunction

    function automatic logic [31:0] align_addr(input mem_op_e op, input logic [31:0] a);
        return a & ~(op_bytes(op) - 1);
    endfunction

    // little-endian read of the shadow memory, extended per opcode
    function automatic logic [31:0] ref_load(input mem_op_e op, input logic [7:0] a);
        logic [31:0] w;
        w = {shadow[a + 8'd3], shadow[a + 8'd2], shadow[a + 8'd1], shadow[a]};
        case (op)
            op_lw:   return w;
            op_lh:   return {{16{w[15]}}, w[15:0]};
            op_lhu:  return {16'h0000, w[15:0]};
            op_lb:   return {{24{w[7]}}, w[7:0]};
            default: return {24'h000000, w[7:0]};
        endcase
    endfunction

    task automatic check_memory();
        for (int i = 0; i < 256; i++) begin
            check_val(l15.mem[i], shadow[i], $sformatf("memory byte %0d", i));
        end
    endtask

    // request stability, fires, acks and done pulses
    always @(negedge clk) begin
        if (nrst) begin
            if (l15_val) begin
                if (held) begin
                    check_val(l15_rqtype, hold_type, "rqtype under back-pressure");
                    check_val(l15_size, hold_size, "size under back-pressure");
                    check_val(l15_address, hold_addr, "address under back-pressure");
                    check_val(l15_data, hold_data, "data under back-pressure");
                end
                hold_type = l15_rqtype;
                hold_size = l15_size;
                hold_addr = l15_address;
                hold_data = l15_data;
                held      = !(l15_ack && l15_header_ack);
                if (l15_ack && l15_header_ack) begin
                    fire_cnt++;
                    last_type = l15_rqtype;
                    last_size = l15_size;
                    last_addr = l15_address;
                    last_data = l15_data;
                end
            end else if (held) begin
                stop_run("l15_val dropped before the request fired");
            end
            if (l15_req_ack) begin
                ack_cnt++;
            end
            if (done) begin
                done_cnt++;
            end
        end
    end

    // entered and left 2 ns after a rising edge
    task automatic run_op(input mem_op_e op, input logic [31:0] a, input logic [31:0] b,
                          input logic [31:0] imm, input logic use_int);
        int          fires0;
        int          acks0;
        int          dones0;
        int          cycles;
        int          n;
        logic        st;
        logic        mis;
        logic [31:0] ea;
        logic [31:0] exp_d;
        logic [31:0] mask;
        logic [1:0]  lane;
        fires0 = fire_cnt;
        acks0  = ack_cnt;
        dones0 = done_cnt;
        st     = (op == op_sw) || (op == op_sh) || (op == op_sb);
        n      = op_bytes(op);
        ea     = st ? a + imm : a + b;
        mis    = (ea[1:0] & 2'(n - 1)) != 2'b00;
        mem_op = op;
        op_a   = a;
        op_b   = b;
        s_imm  = imm;
        int_en = use_int;
        cycles = 0;
        while (done !== 1'b1 && cycles < OP_CYCLES) begin
            @(negedge clk);
            cycles++;
        end
        if (done !== 1'b1) begin
            stop_run($sformatf("no done for %s within %0d cycles", op.name(), OP_CYCLES));
        end
        check_val(ld_misaligned, !st && mis, "ld_misaligned");
        check_val(st_misaligned, st && mis, "st_misaligned");
        check_val(fire_cnt - fires0, mis ? 0 : 1, "requests fired");
        check_val(ack_cnt - acks0, mis ? 0 : 1 + use_int, "returns acked");
        if (!mis && !st) begin
            check_val(last_type, `L15_LOAD_RQ, "load rqtype");
            check_val(load_data, ref_load(op, ea[7:0]), $sformatf("%s load_data", op.name()));
        end
        if (!mis && st) begin
            exp_d = 32'h0;
            mask  = 32'h0;
            for (int j = 0; j < n; j++) begin
                lane = ea[1:0] + 2'(j);
                exp_d[31 - 8 * lane -: 8] = b[8 * j +: 8];
                mask[31 - 8 * lane -: 8]  = 8'hff;
                shadow[ea[7:0] + 8'(j)]   = b[8 * j +: 8];
            end
            check_val(last_type, `L15_STORE_RQ, "store rqtype");
            check_val(last_size, (n == 4) ? `MSG_SIZE_4B : (n == 2) ? `MSG_SIZE_2B
                                                                     : `MSG_SIZE_1B, "store size");
            check_val(last_addr, ea, "store address");
            check_val(last_data & mask, exp_d, "store data");
        end
        @(posedge clk);
        #2;
        mem_op = op_none;
        int_en = 1'b0;
        @(negedge clk);
        check_val(done, 1'b0, "done after one cycle");
        check_val(done_cnt - dones0, 1, "done pulses per op");
        @(posedge clk);
        #2;
    endtask

    initial begin
        #(CLK_PERIOD * (OP_CYCLES * N_OPS + 10));
        stop_run("watchdog timeout, the run did not finish");
    end

    initial begin
        logic [31:0] w;
        mem_op_e     op;
        void'($urandom(9));
        nrst   = 1'b0;
        mem_op = op_none;
        op_a   = 32'h0;
        op_b   = 32'h0;
        s_imm  = 32'h0;
        int_en = 1'b0;
        repeat (5) @(posedge clk);
        #2;
        nrst = 1'b1;
        @(negedge clk);
        check_val(l15_val, 1'b0, "l15_val after reset");
        check_val(done, 1'b0, "done after reset");
        check_val(ld_misaligned, 1'b0, "ld_misaligned after reset");
        check_val(st_misaligned, 1'b0, "st_misaligned after reset");
        for (int i = 0; i < 256; i++) begin
            shadow[i] = l15.mem[i];
        end
        @(posedge clk);
        #2;

        // each word sits in a different lane of its line
        for (int k = 0; k < N_WORDS; k++) begin
            w = 32'h20 + 20 * k;
            run_op(op_sw, w - 8, $urandom, 8, 1'b0);
            for (int o = 0; o < 4; o += 2) begin
                run_op(op_sh, w, $urandom, o, 1'b0);
            end
            for (int o = 0; o < 4; o++) begin
                run_op(op_sb, w + o + 4, $urandom, 32'hffff_fffc, 1'b0);   // negative imm
            end
        end

        for (int k = 0; k < N_RAND; k++) begin
            case ($urandom_range(2, 0))
                0:       op = op_sw;
                1:       op = op_sh;
                default: op = op_sb;
            endcase
            run_op(op, align_addr(op, $urandom_range(255, 0)), $urandom, 0, 1'b0);
        end

        for (int k = 0; k < N_WORDS; k++) begin
            w = 32'h20 + 20 * k;
            run_op(op_lw, w, 0, 0, 1'b0);
            for (int o = 0; o < 4; o += 2) begin
                run_op(op_lh, w, o, 0, 1'b0);
                run_op(op_lhu, w, o, 0, 1'b0);
            end
            for (int o = 0; o < 4; o++) begin
                run_op(op_lb, w, o, 0, 1'b0);
                run_op(op_lbu, w, o, 0, 1'b0);
            end
        end

        // misaligned, no request and memory untouched
        run_op(op_lh, 32'h21, 0, 0, 1'b0);
        run_op(op_lh, 32'h34, 3, 0, 1'b0);
        run_op(op_lhu, 32'h49, 0, 0, 1'b0);
        run_op(op_lw, 32'h20, 1, 0, 1'b0);
        run_op(op_lw, 32'h34, 2, 0, 1'b0);
        run_op(op_lw, 32'h5c, 3, 0, 1'b0);
        run_op(op_sh, 32'h20, $urandom, 1, 1'b0);
        run_op(op_sh, 32'h48, $urandom, 3, 1'b0);
        run_op(op_sw, 32'h34, $urandom, 2, 1'b0);
        check_memory();

        // interrupt return ahead of the load return
        for (int k = 0; k < N_INT; k++) begin
            case ($urandom_range(4, 0))
                0:       op = op_lw;
                1:       op = op_lh;
                2:       op = op_lhu;
                3:       op = op_lb;
                default: op = op_lbu;
            endcase
            run_op(op, align_addr(op, $urandom_range(255, 0)), 0, 0, 1'b1);
        end

        check_memory();
        check_val(done_cnt, N_OPS, "total done pulses");
        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== build.f ====
+incdir+src
src/lsu_pkg.sv
src/lsu_addr_stage.sv
src/lsu_l15_req.sv
src/lsu_load_align.sv
src/lsu_top.sv
test/tb_l15_model.sv
test/tb_lsu.sv

// ==== Makefile ====
# Verilator build and run of the LSU testbench
# pass or fail is decided from the run log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   show this list"
	@echo "  test   build tb_lsu with Verilator, run it, fail unless sim.log holds TEST PASSED"
	@echo "  clean  remove obj_dir and sim.log"

test:
	verilator --binary --timing --assert -Wno-fatal --top-module tb_lsu -f build.f -Mdir obj_dir
	obj_dir/Vtb_lsu | tee sim.log
	grep -q "TEST PASSED" sim.log

clean:
	rm -rf obj_dir sim.log
